// ==== source/preFetch_settings.svh ====
// ==========================================================
// address constants of the pre-fetch stage
// include wherever reset PC, vectors or segment bases are needed
// ==========================================================
`ifndef PREFETCH_SETTINGS_SVH
`define PREFETCH_SETTINGS_SVH

// boot ROM entry, lies in kseg1
`define PREFETCH_RESET_PC     32'hbfc00000

// general exception entry while BEV is set
`define PREFETCH_EXC_VECTOR   32'hbfc00380

// unmapped segments, only the top 3 bits are decoded
`define PREFETCH_KSEG0_BASE   32'h80000000
`define PREFETCH_KSEG1_BASE   32'ha0000000

// tlb C field value for cacheable noncoherent
`define PREFETCH_CACHED_C     3'd3

`endif

// ==== source/preFetchPkg.sv ====
// ==========================================================
// types shared by the pre-fetch stage and its testbench
// redirect bundle, tlb entry and the icache request
// ==========================================================
package preFetchPkg;

    // redirect requested by the memory stage
    typedef enum logic [1:0] {
        exEntryNone      = 2'd0,
        exEntryException = 2'd1,
        exEntryEret      = 2'd2,
        exEntryRefetch   = 2'd3
    } exEntrySel_t;

    // branch resolution from EX
    typedef struct packed {
        logic branchTaken;
        logic regJump;      // jr / jalr
    } branchInfo_t;

    typedef struct packed {
        exEntrySel_t exEntrySel;
        logic [31:0] epc;
        logic [31:0] memPc;
        branchInfo_t branch;
        logic [31:0] exePc;
        logic [31:0] exeImm;
        logic [31:0] exeRegA;    // jr source register
        logic        idImmJump;  // j / jal decoded in ID
        logic [31:0] idPc;
        logic [31:0] idInstr;
    } redirect_t;

    // one even/odd page pair
    typedef struct packed {
        logic [18:0] vpn2;
        logic [19:0] pfn0;
        logic [2:0]  c0;
        logic        v0;
        logic [19:0] pfn1;
        logic [2:0]  c1;
        logic        v1;
    } tlbEntry_t;

    typedef enum logic [1:0] {
        fetchExceptNone       = 2'd0,
        fetchExceptTlbRefill  = 2'd1,
        fetchExceptTlbInvalid = 2'd2
    } fetchExcept_t;

    // request to the instruction cache
    typedef struct packed {
        logic [19:0] tag;       // physical
        logic [7:0]  index;
        logic [3:0]  offset;
        logic        cached;
        logic        valid;
    } fetchReq_t;

endpackage

// ==== source/pcGen.sv ====
// ==========================================================
// program counter and next-PC selection
// pc is written on each edge with pcWrite high
// ==========================================================
`timescale 1ns/1ns

`include "preFetch_settings.svh"

module pcGen (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   pcWrite,
    input  preFetchPkg::redirect_t redirect,
    output logic [31:0]            pc
);
    import preFetchPkg::*;

    localparam logic [31:0] resetPc   = `PREFETCH_RESET_PC;
    localparam logic [31:0] excVector = `PREFETCH_EXC_VECTOR;

    logic [31:0] seqPc;
    logic [31:0] idPcPlus4;
    logic [31:0] jumpTarget;
    logic [31:0] branchTarget;
    logic [31:0] nextPc;

    assign seqPc     = pc + 32'd4;
    assign idPcPlus4 = redirect.idPc + 32'd4;

    // j / jal stays inside the 256MB region of the delay slot
    assign jumpTarget = {idPcPlus4[31:28], redirect.idInstr[25:0], 2'b00};

    // offset counts words from the delay slot
    assign branchTarget = redirect.exePc + 32'd4 + {redirect.exeImm[29:0], 2'b00};

    // later stages win, they flush everything younger
    always_comb begin
        if (redirect.exEntrySel == exEntryException) begin
            nextPc = excVector;
        end else if (redirect.exEntrySel == exEntryEret) begin
            nextPc = redirect.epc;
        end else if (redirect.exEntrySel == exEntryRefetch) begin
            nextPc = redirect.memPc;             // replay the instruction in MEM
        end else if (redirect.branch.branchTaken) begin
            nextPc = branchTarget;
        end else if (redirect.branch.regJump) begin
            nextPc = redirect.exeRegA;
        end else if (redirect.idImmJump) begin
            nextPc = jumpTarget;
        end else begin
            nextPc = seqPc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetPc;
        end else if (pcWrite) begin
            pc <= nextPc;
        end                                      // hold while stalled
    end

endmodule

// ==== source/itlbBuffer.sv ====
// ==========================================================
// single-entry instruction tlb buffer in front of the main tlb
// translates pc, raises stall or fetch exceptions, builds the icache request
// ==========================================================
`timescale 1ns/1ns

`include "preFetch_settings.svh"

module itlbBuffer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [31:0]               pc,
    input  logic                      tlbBufferFlush,
    input  preFetchPkg::tlbEntry_t    tlbLookupEntry,
    input  logic                      tlbLookupFound,
    output logic [18:0]               lookupVpn2,
    output logic                      tlbBufferValid,
    output logic                      tlbStall,
    output preFetchPkg::fetchExcept_t fetchExcept,
    output preFetchPkg::fetchReq_t    fetchReq
);
    import preFetchPkg::*;

    localparam logic [31:0] kseg0Base  = `PREFETCH_KSEG0_BASE;
    localparam logic [31:0] kseg1Base  = `PREFETCH_KSEG1_BASE;
    localparam logic [2:0]  cachedCode = `PREFETCH_CACHED_C;

    tlbEntry_t   bufEntry;
    logic        bufValid;
    tlbEntry_t   activeEntry;

    logic        inKseg0;
    logic        inKseg1;
    logic        mapped;
    logic        bufHit;
    logic        mappedMiss;
    logic        refillMiss;

    logic        oddPage;
    logic [19:0] selPfn;
    logic [2:0]  selC;
    logic        selV;
    logic [19:0] physTag;
    logic        isCached;

    // segment decode on the top three bits
    assign inKseg0 = (pc[31:29] == kseg0Base[31:29]);
    assign inKseg1 = (pc[31:29] == kseg1Base[31:29]);
    assign mapped  = !(inKseg0 || inKseg1);

    assign bufHit     = bufValid && (bufEntry.vpn2 == pc[31:13]);
    assign mappedMiss = mapped && !bufHit;

    // main tlb answers this combinationally
    assign lookupVpn2 = pc[31:13];

    // found entry is captured at the edge, pc hits a cycle later
    assign tlbStall   = mappedMiss && tlbLookupFound;
    assign refillMiss = mappedMiss && !tlbLookupFound;

    // during the stall cycle the lookup answer is already usable
    assign activeEntry = bufHit ? bufEntry : tlbLookupEntry;

    assign oddPage = pc[12];

    always_comb begin
        if (oddPage) begin
            selPfn = activeEntry.pfn1;
            selC   = activeEntry.c1;
            selV   = activeEntry.v1;
        end else begin
            selPfn = activeEntry.pfn0;
            selC   = activeEntry.c0;
            selV   = activeEntry.v0;
        end
    end

    always_comb begin
        if (refillMiss) begin
            fetchExcept = fetchExceptTlbRefill;
        end else if (mapped && !selV) begin
            fetchExcept = fetchExceptTlbInvalid;   // hit or stall cycle
        end else begin
            fetchExcept = fetchExceptNone;
        end
    end

    // unmapped segments drop the top three bits
    assign physTag = mapped ? selPfn : {3'b000, pc[28:12]};

    always_comb begin
        if (inKseg0) begin
            isCached = 1'b1;
        end else if (inKseg1) begin
            isCached = 1'b0;
        end else begin
            isCached = (selC == cachedCode);
        end
    end

    assign fetchReq.tag    = physTag;
    assign fetchReq.index  = pc[11:4];
    assign fetchReq.offset = pc[3:0];
    assign fetchReq.cached = isCached;
    assign fetchReq.valid  = !tlbStall && (fetchExcept == fetchExceptNone);

    assign tlbBufferValid = bufValid;

    // flush beats a refill in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            bufValid <= 1'b0;
        end else if (tlbBufferFlush) begin
            bufValid <= 1'b0;
        end else if (tlbStall) begin
            bufValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlbStall) begin
            bufEntry <= tlbLookupEntry;
        end
    end

endmodule

// ==== source/preFetchTop.sv ====
// ==========================================================
// pre-fetch stage top, pc register plus instruction tlb buffer
// outside control lowers pcWrite while tlbStall is high
// ==========================================================
`timescale 1ns/1ns

module preFetchTop (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      pcWrite,
    input  preFetchPkg::redirect_t    redirect,
    input  preFetchPkg::tlbEntry_t    tlbLookupEntry,
    input  logic                      tlbLookupFound,
    input  logic                      tlbBufferFlush,
    output logic [31:0]               pc,
    output preFetchPkg::fetchReq_t    fetchReq,
    output preFetchPkg::fetchExcept_t fetchExcept,
    output logic [18:0]               lookupVpn2,
    output logic                      tlbBufferValid,
    output logic                      tlbStall
);

    logic [31:0] curPc;   // shared by the top port and the tlb buffer

    assign pc = curPc;

    pcGen pcGen0 (
        .clk      (clk),
        .reset    (reset),
        .pcWrite  (pcWrite),
        .redirect (redirect),
        .pc       (curPc)
    );

    itlbBuffer itlbBuffer0 (
        .clk            (clk),
        .reset          (reset),
        .pc             (curPc),
        .tlbBufferFlush (tlbBufferFlush),
        .tlbLookupEntry (tlbLookupEntry),
        .tlbLookupFound (tlbLookupFound),
        .lookupVpn2     (lookupVpn2),
        .tlbBufferValid (tlbBufferValid),
        .tlbStall       (tlbStall),
        .fetchExcept    (fetchExcept),
        .fetchReq       (fetchReq)
    );

endmodule

// ==== dv/preFetchModel.svh ====
// ==========================================================
// reference model of the pre-fetch stage, included inside the testbench
// main tlb table, next-PC rule and translation rule
// ==========================================================
`ifndef PREFETCH_MODEL_SVH
`define PREFETCH_MODEL_SVH

localparam int tlbSlots = 8;

tlbEntry_t tlbTable [tlbSlots];
logic      tlbPresent [tlbSlots];

// slots 6 and 7 stay empty, slots 2 and 3 each have one dead half
task automatic fillTlbTable();
    for (int i = 0; i < tlbSlots; i++) begin
        tlbTable[i].vpn2 = i[0] ? 19'h60000 + 19'(i) : 19'h00400 + 19'(i);  // kseg2 / kuseg
        tlbTable[i].pfn0 = 20'($urandom);
        tlbTable[i].c0   = (($urandom % 2) == 0) ? `PREFETCH_CACHED_C : 3'd2;
        tlbTable[i].v0   = 1'b1;
        tlbTable[i].pfn1 = 20'($urandom);
        tlbTable[i].c1   = (($urandom % 2) == 0) ? `PREFETCH_CACHED_C : 3'd2;
        tlbTable[i].v1   = 1'b1;
        tlbPresent[i]    = (i < 6);
    end
    tlbTable[0].c0 = `PREFETCH_CACHED_C;   // even half cached, odd half not
    tlbTable[0].c1 = 3'd2;
    tlbTable[2].v0 = 1'b0;
    tlbTable[3].v1 = 1'b0;
endtask

function automatic void lookupModel(input logic [18:0] vpn2, output logic found,
                                    output tlbEntry_t entry);
    found = 1'b0;
    entry = '0;
    for (int i = 0; i < tlbSlots; i++) begin
        if (tlbPresent[i] && (tlbTable[i].vpn2 == vpn2)) begin
            found = 1'b1;
            entry = tlbTable[i];
        end
    end
endfunction

// first matching source wins
function automatic logic [31:0] refNextPc(input redirect_t r, input logic [31:0] curPc);
    logic [31:0] slotPc;
    slotPc = r.idPc + 32'd4;
    if (r.exEntrySel == exEntryException) begin
        return `PREFETCH_EXC_VECTOR;
    end else if (r.exEntrySel == exEntryEret) begin
        return r.epc;
    end else if (r.exEntrySel == exEntryRefetch) begin
        return r.memPc;
    end else if (r.branch.branchTaken) begin
        return r.exePc + 32'd4 + (r.exeImm << 2);
    end else if (r.branch.regJump) begin
        return r.exeRegA;
    end else if (r.idImmJump) begin
        return {slotPc[31:28], r.idInstr[25:0], 2'b00};
    end
    return curPc + 32'd4;
endfunction

function automatic void refTranslate(input logic [31:0] pcIn, input logic bufValid,
                                     input tlbEntry_t bufEntry, output logic stall,
                                     output fetchExcept_t exc, output fetchReq_t req);
    logic      found;
    tlbEntry_t looked;
    tlbEntry_t useEntry;
    logic      seg0;
    logic      seg1;
    logic      mappedPc;
    logic      hit;
    logic      halfValid;
    seg0     = (pcIn[31:29] == 3'b100);   // 0x80000000 .. 0x9fffffff
    seg1     = (pcIn[31:29] == 3'b101);   // 0xa0000000 .. 0xbfffffff
    mappedPc = !(seg0 || seg1);
    hit      = bufValid && (bufEntry.vpn2 == pcIn[31:13]);
    lookupModel(pcIn[31:13], found, looked);
    useEntry  = hit ? bufEntry : looked;
    halfValid = pcIn[12] ? useEntry.v1 : useEntry.v0;
    stall     = mappedPc && !hit && found;
    if (mappedPc && !hit && !found) begin
        exc = fetchExceptTlbRefill;
    end else if (mappedPc && !halfValid) begin
        exc = fetchExceptTlbInvalid;
    end else begin
        exc = fetchExceptNone;
    end
    req.index  = pcIn[11:4];
    req.offset = pcIn[3:0];
    req.valid  = !stall && (exc == fetchExceptNone);
    if (!mappedPc) begin
        req.tag    = {3'b000, pcIn[28:12]};
        req.cached = seg0;
    end else if (pcIn[12]) begin
        req.tag    = useEntry.pfn1;
        req.cached = (useEntry.c1 == `PREFETCH_CACHED_C);
    end else begin
        req.tag    = useEntry.pfn0;
        req.cached = (useEntry.c0 == `PREFETCH_CACHED_C);
    end
endfunction

`endif

// ==== dv/preFetchTb.sv ====
// ==========================================================
// testbench of the pre-fetch stage, random redirects plus directed tlb cases
// outputs are compared against the included reference model every cycle
// ==========================================================
`timescale 1ns/1ns

`include "preFetch_settings.svh"

module preFetchTb;
    import preFetchPkg::*;

    `include "preFetchModel.svh"

    localparam int waitLimit = 20;

    logic         clk;
    logic         reset;
    logic         pcWrite;
    redirect_t    redirect;
    tlbEntry_t    tlbLookupEntry;
    logic         tlbLookupFound;
    logic         tlbBufferFlush;
    logic [31:0]  pc;
    fetchReq_t    fetchReq;
    fetchExcept_t fetchExcept;
    logic [18:0]  lookupVpn2;
    logic         tlbBufferValid;
    logic         tlbStall;

    // reference state, updated at each rising edge
    logic [31:0]  modelPc;
    logic         modelBufValid;
    tlbEntry_t    modelBufEntry;
    logic [31:0]  nextPc;
    logic         nextBufValid;
    tlbEntry_t    nextBufEntry;
    logic         expStall;
    fetchExcept_t expExcept;
    fetchReq_t    expReq;
    logic         capFound;
    logic         prevStall;
    logic         prevFlush;

    int           errors;
    int           cyclesChecked;
    logic         timedOut;
    redirect_t    noRedirect;
    logic         stalled;

    preFetchTop dut0 (
        .clk            (clk),
        .reset          (reset),
        .pcWrite        (pcWrite),
        .redirect       (redirect),
        .tlbLookupEntry (tlbLookupEntry),
        .tlbLookupFound (tlbLookupFound),
        .tlbBufferFlush (tlbBufferFlush),
        .pc             (pc),
        .fetchReq       (fetchReq),
        .fetchExcept    (fetchExcept),
        .lookupVpn2     (lookupVpn2),
        .tlbBufferValid (tlbBufferValid),
        .tlbStall       (tlbStall)
    );

    always #2 clk = ~clk;

    // main tlb answers the lookup in the same cycle
    always_comb begin
        lookupModel(lookupVpn2, tlbLookupFound, tlbLookupEntry);
    end

    function automatic logic [31:0] randomTarget();
        logic [31:0] r;
        int          kind;
        int          slot;
        r    = $urandom;
        kind = int'($urandom % 8);
        slot = int'($urandom % 8);
        case (kind)
            0, 1:       return {3'b100, r[28:2], 2'b00};            // kseg0
            2:          return {3'b101, r[28:2], 2'b00};            // kseg1
            3, 4, 5, 6: return {tlbTable[slot].vpn2, r[12:2], 2'b00};
            default:    return {r[31:2], 2'b00};
        endcase
    endfunction

    // several sources are often active together
    function automatic redirect_t randomRedirect();
        redirect_t   r;
        logic [31:0] pick;
        pick                 = $urandom;
        r.exEntrySel         = (pick[3:2] == 2'b00) ? exEntrySel_t'(pick[1:0]) : exEntryNone;
        r.epc                = randomTarget();
        r.memPc              = randomTarget();
        r.branch.branchTaken = (pick[5:4] == 2'b00);
        r.branch.regJump     = (pick[7:6] == 2'b00);
        r.idImmJump          = (pick[9:8] == 2'b00);
        r.exePc              = randomTarget();
        r.exeImm             = {{26{pick[15]}}, pick[15:10]};
        r.exeRegA            = randomTarget();
        r.idPc               = randomTarget();
        r.idInstr            = $urandom;
        return r;
    endfunction

    function automatic redirect_t eretTo(input logic [31:0] addr);
        redirect_t r;
        r            = '0;
        r.exEntrySel = exEntryEret;
        r.epc        = addr;
        return r;
    endfunction

    function automatic logic [31:0] pageAddr(input int slot, input logic odd);
        return {tlbTable[slot].vpn2, odd, 12'h000};
    endfunction

    // pcWrite follows the stall seen just after the edge
    task automatic driveCycle(input redirect_t r, input logic flush, input logic hold,
                              output logic stallSeen);
        @(posedge clk);
        #1;
        stallSeen      = tlbStall;
        pcWrite        = !tlbStall && !hold;
        redirect       = r;
        tlbBufferFlush = flush;
    endtask

    task automatic runCycles(input int count);
        logic s;
        for (int i = 0; i < count; i++) begin
            driveCycle(noRedirect, 1'b0, 1'b0, s);
        end
    endtask

    task automatic jumpTo(input logic [31:0] addr);
        logic s;
        if (timedOut) return;
        for (int i = 0; i < waitLimit; i++) begin
            driveCycle(eretTo(addr), 1'b0, 1'b0, s);
            if (!s) return;                  // written at the next edge
        end
        timedOut = 1'b1;
        $display("timeout: pc write to %h never accepted", addr);
    endtask

    // kind 0 waits for a stall, 1 for a refill, 2 for an invalid fetch
    task automatic waitFor(input int kind, input string what);
        logic s;
        logic seen;
        if (timedOut) return;
        for (int i = 0; i < waitLimit; i++) begin
            driveCycle(noRedirect, 1'b0, 1'b0, s);
            if (kind == 0) begin
                seen = s;
            end else if (kind == 1) begin
                seen = (fetchExcept == fetchExceptTlbRefill);
            end else begin
                seen = (fetchExcept == fetchExceptTlbInvalid);
            end
            if (seen) return;
        end
        timedOut = 1'b1;
        $display("timeout: no %s within %0d cycles", what, waitLimit);
    endtask

    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
        errors++;
        $display("error at %0t: %s mismatch, got %h expected %h", $time, what, got, exp);
    endtask

    // compare just before the edge, then advance the model
    initial begin
        forever begin
            @(negedge clk);
            if (!reset) begin
                cyclesChecked++;
                refTranslate(modelPc, modelBufValid, modelBufEntry, expStall, expExcept, expReq);
                if (pc !== modelPc) reportMismatch("pc", pc, modelPc);
                if (tlbStall !== expStall) reportMismatch("tlbStall", 32'(tlbStall), 32'(expStall));
                if (fetchExcept !== expExcept) begin
                    reportMismatch("fetchExcept", 32'(fetchExcept), 32'(expExcept));
                end
                if (tlbBufferValid !== modelBufValid) begin
                    reportMismatch("tlbBufferValid", 32'(tlbBufferValid), 32'(modelBufValid));
                end
                if (lookupVpn2 !== modelPc[31:13]) begin
                    reportMismatch("lookupVpn2", 32'(lookupVpn2), 32'(modelPc[31:13]));
                end
                if (fetchReq.valid !== expReq.valid) begin
                    reportMismatch("fetchReq.valid", 32'(fetchReq.valid), 32'(expReq.valid));
                end
                if ({fetchReq.index, fetchReq.offset} !== {expReq.index, expReq.offset}) begin
                    reportMismatch("fetchReq index/offset", 32'({fetchReq.index, fetchReq.offset}),
                                   32'({expReq.index, expReq.offset}));
                end
                if (expReq.valid && (fetchReq.tag !== expReq.tag)) begin
                    reportMismatch("fetchReq.tag", 32'(fetchReq.tag), 32'(expReq.tag));
                end
                if (expReq.valid && (fetchReq.cached !== expReq.cached)) begin
                    reportMismatch("fetchReq.cached", 32'(fetchReq.cached), 32'(expReq.cached));
                end
                if (tlbStall && prevStall && !prevFlush) begin
                    errors++;
                    $display("error at %0t: tlb stall lasted more than one cycle", $time);
                end
                nextPc       = pcWrite ? refNextPc(redirect, modelPc) : modelPc;
                nextBufValid = modelBufValid;
                nextBufEntry = modelBufEntry;
                if (expStall) lookupModel(modelPc[31:13], capFound, nextBufEntry);
                if (tlbBufferFlush) begin
                    nextBufValid = 1'b0;               // flush wins over capture
                end else if (expStall) begin
                    nextBufValid = 1'b1;
                end
                prevStall = tlbStall;
                prevFlush = tlbBufferFlush;
            end else begin
                nextPc       = `PREFETCH_RESET_PC;
                nextBufValid = 1'b0;
                nextBufEntry = modelBufEntry;
                prevStall    = 1'b0;
                prevFlush    = 1'b0;
            end
            @(posedge clk);
            modelPc       = nextPc;
            modelBufValid = nextBufValid;
            modelBufEntry = nextBufEntry;
        end
    end

    initial begin
        void'($urandom(32'h30f1));
        clk            = 1'b0;
        reset          = 1'b1;
        pcWrite        = 1'b0;
        redirect       = '0;
        tlbBufferFlush = 1'b0;
        noRedirect     = '0;
        modelPc        = '0;
        modelBufValid  = 1'b0;
        modelBufEntry  = '0;
        prevStall      = 1'b0;
        prevFlush      = 1'b0;
        errors         = 0;
        cyclesChecked  = 0;
        timedOut       = 1'b0;
        fillTlbTable();

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        if (pc !== `PREFETCH_RESET_PC) reportMismatch("pc after reset", pc, `PREFETCH_RESET_PC);

        runCycles(20);                                 // sequential kseg1 fetch

        for (int i = 0; i < 400; i++) begin
            driveCycle(randomRedirect(), (($urandom % 16) == 0), (($urandom % 6) == 0), stalled);
        end

        // refill from the main tlb, both halves of slot 0
        driveCycle(noRedirect, 1'b1, 1'b0, stalled);
        jumpTo(pageAddr(0, 1'b0));
        waitFor(0, "tlb stall on even page");
        runCycles(6);
        jumpTo(pageAddr(0, 1'b1) + 32'h40);
        runCycles(6);

        jumpTo(pageAddr(6, 1'b0));                     // empty slot
        waitFor(1, "tlb refill exception");
        jumpTo(pageAddr(2, 1'b0));                     // v0 cleared
        waitFor(2, "tlb invalid exception");
        runCycles(3);

        driveCycle(noRedirect, 1'b1, 1'b0, stalled);
        driveCycle(noRedirect, 1'b0, 1'b0, stalled);
        if (tlbBufferValid !== 1'b0) begin
            errors++;
            $display("error at %0t: tlb buffer still valid after flush", $time);
        end
        jumpTo(pageAddr(4, 1'b1));
        waitFor(0, "tlb stall after flush");

        jumpTo(32'h80001000);
        for (int i = 0; i < 10; i++) begin
            driveCycle(noRedirect, 1'b0, 1'b0, stalled);
            if (stalled) begin
                errors++;
                $display("error at %0t: stall on unmapped kseg0 pc %h", $time, pc);
            end
        end
        runCycles(2);

        $display("cycles checked %0d, errors %0d, timeouts %0d",
                 cyclesChecked, errors, timedOut);
        if ((errors == 0) && !timedOut) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== preFetchTop.f ====
+incdir+source
+incdir+dv
source/preFetchPkg.sv
source/pcGen.sv
source/itlbBuffer.sv
source/preFetchTop.sv
dv/preFetchTb.sv

// ==== runSim.sh ====
#!/bin/sh
# builds the pre-fetch testbench with verilator and runs it
# exit status is 0 only when the run reports a pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns \
    --top-module preFetchTb -f preFetchTop.f -o preFetchSim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

simOut=$(./obj_dir/preFetchSim)
status=$?
printf '%s\n' "$simOut"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "Test OK"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi
